// ==== hw/mips_decode_consts.svh ====
`ifndef MIPS_DECODE_CONSTS_SVH
`define MIPS_DECODE_CONSTS_SVH

`define DATA_W          32
`define REG_ADDR_W      5
`define SHAMT_W         5
`define IMM_W           16
`define OPCODE_W        6
`define FUNCT_W         6
`define NUM_REGS        32
`define FIFO_DEPTH_DEF  4

// opcode field, inst[31:26]
`define OP_SPECIAL      6'b000000
`define OP_ADDI         6'b001000
`define OP_ADDIU        6'b001001
`define OP_SLTI         6'b001010
`define OP_SLTIU        6'b001011
`define OP_ANDI         6'b001100
`define OP_ORI          6'b001101
`define OP_XORI         6'b001110
`define OP_LUI          6'b001111
`define OP_PREF         6'b110011

// funct field, inst[5:0]
`define FN_SLL          6'b000000
`define FN_SRL          6'b000010
`define FN_SRA          6'b000011
`define FN_SLLV         6'b000100
`define FN_SRLV         6'b000110
`define FN_SRAV         6'b000111
`define FN_SYNC         6'b001111
`define FN_ADD          6'b100000
`define FN_ADDU         6'b100001
`define FN_SUB          6'b100010
`define FN_SUBU         6'b100011
`define FN_AND          6'b100100
`define FN_OR           6'b100101
`define FN_XOR          6'b100110
`define FN_NOR          6'b100111
`define FN_SLT          6'b101010
`define FN_SLTU         6'b101011

`endif

// ==== hw/mips_decode_pkg.sv ====
`include "mips_decode_consts.svh"

package mips_decode_pkg;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_ADD,  // add/addu/addi/addiu, no trap
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef logic [`DATA_W-1:0]     data_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef struct packed {
        alu_op_e              op;
        logic                 we;
        logic                 illegal;
        logic                 use_imm;         // operand b is imm, not rt
        logic                 shamt_from_imm;  // shift by shamt field, not rs
        logic [`SHAMT_W-1:0]  shamt;
    } dec_ctrl_t;

    typedef struct packed {
        reg_addr_t rs;
        reg_addr_t rt;
    } dec_src_t;

    typedef struct packed {
        dec_ctrl_t ctrl;
        dec_src_t  src;
        reg_addr_t dst;
        data_t     imm;  // already extended
    } dec_op_t;

endpackage

// ==== hw/dec_op_if.sv ====
`timescale 1ns/1ps

interface dec_op_if;
    import mips_decode_pkg::*;

    logic      req;
    logic      ack;
    dec_ctrl_t ctrl;
    dec_src_t  src;
    reg_addr_t dst;
    data_t     imm;

    modport sender (
        output req, ctrl, src, dst, imm,
        input  ack
    );

    modport receiver (
        input  req, ctrl, src, dst, imm,
        output ack
    );

endinterface

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ps
`include "mips_decode_consts.svh"

module inst_decoder (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   inst_req_i,
    input  mips_decode_pkg::data_t inst_i,
    output logic                   inst_ack_o,
    dec_op_if.sender               dec_o
);
    import mips_decode_pkg::*;

    typedef enum logic [1:0] {S_EMPTY, S_FULL, S_REQ, S_DONE} hold_state_e;

    logic [`OPCODE_W-1:0] opcode;
    logic [`FUNCT_W-1:0]  funct;
    logic [`SHAMT_W-1:0]  shamt;
    logic [`IMM_W-1:0]    imm16;
    reg_addr_t            rs;
    reg_addr_t            rt;
    reg_addr_t            rd;
    alu_op_e              alu_op;
    logic                 we;
    logic                 legal;
    logic                 imm_form;
    logic                 sh_imm;
    data_t                imm_val;
    dec_op_t              dec_d;
    dec_op_t              hold_q;
    hold_state_e          state_q;
    logic                 capture;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];

    always_comb begin
        alu_op   = ALU_NOP;
        we       = 1'b0;
        legal    = 1'b0;
        imm_form = 1'b0;
        sh_imm   = 1'b0;
        imm_val  = '0;

        case (opcode)
            `OP_SPECIAL: begin
                // r-type needs a clear shamt field
                if (shamt == '0) begin
                    legal = 1'b1;
                    we    = 1'b1;
                    case (funct)
                        `FN_AND:           alu_op = ALU_AND;
                        `FN_OR:            alu_op = ALU_OR;
                        `FN_XOR:           alu_op = ALU_XOR;
                        `FN_NOR:           alu_op = ALU_NOR;
                        `FN_SLLV:          alu_op = ALU_SLL;
                        `FN_SRLV:          alu_op = ALU_SRL;
                        `FN_SRAV:          alu_op = ALU_SRA;
                        `FN_ADD, `FN_ADDU: alu_op = ALU_ADD;
                        `FN_SUB, `FN_SUBU: alu_op = ALU_SUB;
                        `FN_SLT:           alu_op = ALU_SLT;
                        `FN_SLTU:          alu_op = ALU_SLTU;
                        `FN_SYNC:          we = 1'b0;
                        default: begin
                            legal = 1'b0;
                            we    = 1'b0;
                        end
                    endcase
                end
            end
            `OP_ANDI: begin
                alu_op   = ALU_AND;
                imm_form = 1'b1;
                imm_val  = {{(`DATA_W-`IMM_W){1'b0}}, imm16};  // zero ext
            end
            `OP_ORI: begin
                alu_op   = ALU_OR;
                imm_form = 1'b1;
                imm_val  = {{(`DATA_W-`IMM_W){1'b0}}, imm16};
            end
            `OP_XORI: begin
                alu_op   = ALU_XOR;
                imm_form = 1'b1;
                imm_val  = {{(`DATA_W-`IMM_W){1'b0}}, imm16};
            end
            `OP_LUI: begin
                alu_op   = ALU_OR;  // rs | upper imm
                imm_form = 1'b1;
                imm_val  = {imm16, {(`DATA_W-`IMM_W){1'b0}}};
            end
            `OP_ADDI, `OP_ADDIU: begin
                alu_op   = ALU_ADD;
                imm_form = 1'b1;
                imm_val  = {{(`DATA_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};  // sign ext
            end
            `OP_SLTI: begin
                alu_op   = ALU_SLT;
                imm_form = 1'b1;
                imm_val  = {{(`DATA_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
            end
            `OP_SLTIU: begin
                alu_op   = ALU_SLTU;
                imm_form = 1'b1;
                imm_val  = {{(`DATA_W-`IMM_W){imm16[`IMM_W-1]}}, imm16};
            end
            `OP_PREF: legal = 1'b1;
            default: legal = 1'b0;
        endcase

        if (imm_form) begin
            legal = 1'b1;
            we    = 1'b1;
        end

        // sll/srl/sra only with opcode and rs zero
        if (inst_i[31:21] == '0) begin
            if (funct == `FN_SLL || funct == `FN_SRL || funct == `FN_SRA) begin
                legal  = 1'b1;
                we     = 1'b1;
                sh_imm = 1'b1;
                case (funct)
                    `FN_SLL: alu_op = ALU_SLL;
                    `FN_SRL: alu_op = ALU_SRL;
                    default: alu_op = ALU_SRA;
                endcase
            end
        end

        dec_d.ctrl.op             = legal ? alu_op : ALU_NOP;
        dec_d.ctrl.we             = we & legal;
        dec_d.ctrl.illegal        = !legal;
        dec_d.ctrl.use_imm        = imm_form;
        dec_d.ctrl.shamt_from_imm = sh_imm;
        dec_d.ctrl.shamt          = shamt;
        dec_d.src.rs              = rs;
        dec_d.src.rt              = rt;
        dec_d.dst                 = imm_form ? rt : rd;
        dec_d.imm                 = imm_val;
    end

    assign capture = inst_req_i && !inst_ack_o && (state_q == S_EMPTY);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            inst_ack_o <= 1'b0;
        end else if (capture) begin
            inst_ack_o <= 1'b1;
        end else if (!inst_req_i) begin
            inst_ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_EMPTY;
        end else begin
            case (state_q)
                S_EMPTY: if (capture) state_q <= S_FULL;
                S_FULL:  state_q <= S_REQ;
                S_REQ:   if (dec_o.ack) state_q <= S_DONE;
                S_DONE:  if (!dec_o.ack) state_q <= S_EMPTY;  // hold frees here
                default: state_q <= S_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            hold_q <= dec_d;
        end
    end

    assign dec_o.req  = (state_q == S_REQ);
    assign dec_o.ctrl = hold_q.ctrl;
    assign dec_o.src  = hold_q.src;
    assign dec_o.dst  = hold_q.dst;
    assign dec_o.imm  = hold_q.imm;

    // fifo ack only answers a pending req
    a_dec_ack_on_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(dec_o.ack) |-> dec_o.req);

endmodule

// ==== hw/op_fifo.sv ====
`timescale 1ns/1ps
`include "mips_decode_consts.svh"

module op_fifo #(
    parameter int DEPTH = `FIFO_DEPTH_DEF
) (
    input  logic        clk_i,
    input  logic        arst_n_i,
    dec_op_if.receiver  in_o,
    dec_op_if.sender    out_o
);
    import mips_decode_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    dec_op_t          mem_q [DEPTH];
    dec_op_t          wr_word;
    dec_op_t          head;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;  // wrap for non pow2
    endfunction

    assign full    = (count_q == CNT_W'(DEPTH));
    assign empty   = (count_q == '0);
    assign push    = in_o.req && !in_o.ack && !full;
    assign pop     = out_o.req && out_o.ack;
    assign wr_word = {in_o.ctrl, in_o.src, in_o.dst, in_o.imm};
    assign head    = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= wr_word;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // input side, ack follows req one edge late
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            in_o.ack <= 1'b0;
        end else if (push) begin
            in_o.ack <= 1'b1;
        end else if (!in_o.req) begin
            in_o.ack <= 1'b0;
        end
    end

    // output side
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_o.req <= 1'b0;
        end else if (pop) begin
            out_o.req <= 1'b0;
        end else if (!empty && !out_o.ack) begin
            out_o.req <= 1'b1;
        end
    end

    assign out_o.ctrl = head.ctrl;
    assign out_o.src  = head.src;
    assign out_o.dst  = head.dst;
    assign out_o.imm  = head.imm;

    a_no_write_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(in_o.ack) |-> $past(count_q) < CNT_W'(DEPTH));

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(out_o.req) |-> $past(count_q) != '0);

endmodule

// ==== hw/alu_exec.sv ====
`timescale 1ns/1ps
`include "mips_decode_consts.svh"

module alu_exec (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    dec_op_if.receiver                 op_i,
    output logic                       wb_req_o,
    output logic                       wb_we_o,
    output logic                       wb_illegal_o,
    output mips_decode_pkg::reg_addr_t wb_addr_o,
    output mips_decode_pkg::data_t     wb_data_o,
    input  logic                       wb_ack_i
);
    import mips_decode_pkg::*;

    data_t               rf_q [`NUM_REGS];
    data_t               rs_val;
    data_t               rt_val;
    data_t               op_b;
    data_t               result;
    logic [`SHAMT_W-1:0] sh_amt;
    logic                accept;
    logic                rf_we;

    // r0 reads zero
    assign rs_val = (op_i.src.rs == '0) ? '0 : rf_q[op_i.src.rs];
    assign rt_val = (op_i.src.rt == '0) ? '0 : rf_q[op_i.src.rt];
    assign op_b   = op_i.ctrl.use_imm ? op_i.imm : rt_val;
    assign sh_amt = op_i.ctrl.shamt_from_imm ? op_i.ctrl.shamt : rs_val[`SHAMT_W-1:0];

    always_comb begin
        case (op_i.ctrl.op)
            ALU_AND:  result = rs_val & op_b;
            ALU_OR:   result = rs_val | op_b;
            ALU_XOR:  result = rs_val ^ op_b;
            ALU_NOR:  result = ~(rs_val | op_b);
            ALU_SLL:  result = rt_val << sh_amt;
            ALU_SRL:  result = rt_val >> sh_amt;
            ALU_SRA:  result = $signed(rt_val) >>> sh_amt;
            ALU_ADD:  result = rs_val + op_b;  // wraps
            ALU_SUB:  result = rs_val - op_b;
            ALU_SLT:  result = {{(`DATA_W-1){1'b0}}, $signed(rs_val) < $signed(op_b)};
            ALU_SLTU: result = {{(`DATA_W-1){1'b0}}, rs_val < op_b};
            default:  result = '0;
        endcase
    end

    // one op in flight, next only after wb side is idle
    assign accept = op_i.req && !op_i.ack && !wb_req_o && !wb_ack_i;
    assign rf_we  = accept && op_i.ctrl.we && (op_i.dst != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                rf_q[i] <= '0;
            end
        end else if (rf_we) begin
            rf_q[op_i.dst] <= result;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            wb_we_o      <= op_i.ctrl.we;
            wb_illegal_o <= op_i.ctrl.illegal;
            wb_addr_o    <= op_i.dst;
            wb_data_o    <= result;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_req_o <= 1'b0;
            op_i.ack <= 1'b0;
        end else if (accept) begin
            wb_req_o <= 1'b1;
            op_i.ack <= 1'b1;
        end else begin
            if (wb_req_o && wb_ack_i) wb_req_o <= 1'b0;
            if (op_i.ack && !op_i.req) op_i.ack <= 1'b0;
        end
    end

    // wb ack may only rise against a pending record
    a_wb_ack_on_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(wb_ack_i) |-> wb_req_o);

endmodule

// ==== hw/mips_decode_core.sv ====
`timescale 1ns/1ps

module mips_decode_core (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  logic                       inst_req_i,
    input  mips_decode_pkg::data_t     inst_i,
    output logic                       inst_ack_o,
    output logic                       wb_req_o,
    output logic                       wb_we_o,
    output logic                       wb_illegal_o,
    output mips_decode_pkg::reg_addr_t wb_addr_o,
    output mips_decode_pkg::data_t     wb_data_o,
    input  logic                       wb_ack_i
);

    dec_op_if dec_if ();  // decoder to fifo
    dec_op_if exe_if ();  // fifo to execute

    inst_decoder u_inst_decoder (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .inst_req_i (inst_req_i),
        .inst_i     (inst_i),
        .inst_ack_o (inst_ack_o),
        .dec_o      (dec_if.sender)
    );

    op_fifo u_op_fifo (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .in_o     (dec_if.receiver),
        .out_o    (exe_if.sender)
    );

    alu_exec u_alu_exec (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .op_i         (exe_if.receiver),
        .wb_req_o     (wb_req_o),
        .wb_we_o      (wb_we_o),
        .wb_illegal_o (wb_illegal_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .wb_ack_i     (wb_ack_i)
    );

endmodule

// ==== testbench/tb_mips_decode_core.sv ====
`timescale 1ns/1ps
`include "mips_decode_consts.svh"

module tb_mips_decode_core;

    localparam int CLK_PERIOD  = 40;
    localparam int N_READ      = `NUM_REGS;
    localparam int N_IMM       = 200;
    localparam int N_RTYPE     = 300;
    localparam int N_R0        = 8;
    localparam int N_NOP       = 60;
    localparam int N_BURST     = 12;
    localparam int STALL_WAIT  = 100;  // cycles with wb_ack_i withheld
    localparam int TOTAL_INSTS = 2 * N_READ + N_IMM + N_RTYPE + 2 * N_R0 + N_NOP + N_BURST;

    typedef struct packed {
        logic                   we;
        logic                   illegal;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`DATA_W-1:0]     data;
    } wb_rec_t;

    logic                   clk_i;
    logic                   arst_n_i;
    logic                   inst_req_i;
    logic [`DATA_W-1:0]     inst_i;
    logic                   inst_ack_o;
    logic                   wb_req_o;
    logic                   wb_we_o;
    logic                   wb_illegal_o;
    logic [`REG_ADDR_W-1:0] wb_addr_o;
    logic [`DATA_W-1:0]     wb_data_o;
    logic                   wb_ack_i;

    integer             seed;
    integer             ack_seed;
    logic [`DATA_W-1:0] model_rf [`NUM_REGS];
    wb_rec_t            exp_q [$];
    int                 errors;
    int                 checks;
    int                 tests;
    int                 accepted;
    int                 err_mark;
    int                 chk_mark;
    bit                 stall_mode;
    bit                 hold_ack;

    mips_decode_core u_mips_decode_core (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_req_i   (inst_req_i),
        .inst_i       (inst_i),
        .inst_ack_o   (inst_ack_o),
        .wb_req_o     (wb_req_o),
        .wb_we_o      (wb_we_o),
        .wb_illegal_o (wb_illegal_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .wb_ack_i     (wb_ack_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic opcode_supported(input logic [5:0] op);
        case (op)
            `OP_SPECIAL, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_PREF: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // reference model, applied in issue order
    function automatic wb_rec_t model_exec(input logic [31:0] w);
        logic [5:0]  opcode;
        logic [5:0]  funct;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] zext;
        logic [31:0] sext;
        logic [31:0] res;
        logic        legal;
        logic        we;
        wb_rec_t     rec;
        opcode = w[31:26];
        rs     = w[25:21];
        rt     = w[20:16];
        rd     = w[15:11];
        shamt  = w[10:6];
        funct  = w[5:0];
        a      = model_rf[rs];
        b      = model_rf[rt];
        zext   = {16'h0000, w[15:0]};
        sext   = {{16{w[15]}}, w[15:0]};
        res    = '0;
        legal  = 1'b1;
        we     = 1'b1;
        case (opcode)
            `OP_SPECIAL: begin
                if (funct == `FN_SLL || funct == `FN_SRL || funct == `FN_SRA) begin
                    legal = (rs == 5'd0);
                    if (funct == `FN_SLL) res = b << shamt;
                    else if (funct == `FN_SRL) res = b >> shamt;
                    else res = $signed(b) >>> shamt;
                end else if (shamt != 5'd0) begin
                    legal = 1'b0;
                end else begin
                    case (funct)
                        `FN_AND:           res = a & b;
                        `FN_OR:            res = a | b;
                        `FN_XOR:           res = a ^ b;
                        `FN_NOR:           res = ~(a | b);
                        `FN_SLLV:          res = b << a[4:0];
                        `FN_SRLV:          res = b >> a[4:0];
                        `FN_SRAV:          res = $signed(b) >>> a[4:0];
                        `FN_ADD, `FN_ADDU: res = a + b;
                        `FN_SUB, `FN_SUBU: res = a - b;
                        `FN_SLT:           res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        `FN_SLTU:          res = (a < b) ? 32'd1 : 32'd0;
                        `FN_SYNC:          we = 1'b0;
                        default:           legal = 1'b0;
                    endcase
                end
            end
            `OP_ANDI:             res = a & zext;
            `OP_ORI:              res = a | zext;
            `OP_XORI:             res = a ^ zext;
            `OP_LUI:              res = a | {w[15:0], 16'h0000};
            `OP_ADDI, `OP_ADDIU:  res = a + sext;
            `OP_SLTI:             res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            `OP_SLTIU:            res = (a < sext) ? 32'd1 : 32'd0;
            `OP_PREF:             we = 1'b0;
            default:              legal = 1'b0;
        endcase
        if (!legal) begin
            we  = 1'b0;
            res = '0;
        end
        rec.we      = we;
        rec.illegal = !legal;
        rec.addr    = (opcode == `OP_SPECIAL || opcode == `OP_PREF) ? rd : rt;
        rec.data    = res;
        if (we && rec.addr != 5'd0) model_rf[rec.addr] = res;
        return rec;
    endfunction

    function automatic logic [31:0] gen_imm_word();
        logic [5:0]  op;
        logic [31:0] r;
        r = $random(seed);
        case (rand_below(8))
            0:       op = `OP_ANDI;
            1:       op = `OP_ORI;
            2:       op = `OP_XORI;
            3:       op = `OP_LUI;
            4:       op = `OP_ADDI;
            5:       op = `OP_ADDIU;
            6:       op = `OP_SLTI;
            default: op = `OP_SLTIU;
        endcase
        return {op, r[25:0]};
    endfunction

    function automatic logic [31:0] gen_rtype_word();
        logic [5:0]  fn;
        logic [31:0] r;
        int unsigned k;
        r = $random(seed);
        k = rand_below(16);
        case (k)
            0:       fn = `FN_AND;
            1:       fn = `FN_OR;
            2:       fn = `FN_XOR;
            3:       fn = `FN_NOR;
            4:       fn = `FN_SLLV;
            5:       fn = `FN_SRLV;
            6:       fn = `FN_SRAV;
            7:       fn = `FN_ADD;
            8:       fn = `FN_ADDU;
            9:       fn = `FN_SUB;
            10:      fn = `FN_SUBU;
            11:      fn = `FN_SLT;
            12:      fn = `FN_SLTU;
            13:      fn = `FN_SLL;
            14:      fn = `FN_SRL;
            default: fn = `FN_SRA;
        endcase
        if (k >= 13) return {`OP_SPECIAL, 5'd0, r[20:6], fn};  // shamt form, rs zero
        return {`OP_SPECIAL, r[25:11], 5'd0, fn};
    endfunction

    function automatic logic [31:0] gen_nop_word();
        logic [5:0]  op;
        logic [31:0] r;
        r = $random(seed);
        case (rand_below(3))
            0: return {`OP_SPECIAL, r[25:11], 5'd0, `FN_SYNC};
            1: return {`OP_PREF, r[25:0]};
            default: begin
                op = 6'(rand_below(64));
                while (opcode_supported(op)) op = 6'(rand_below(64));
                return {op, r[25:0]};
            end
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // four-phase handshake on the instruction side
    task automatic send_inst(input logic [31:0] word);
        exp_q.push_back(model_exec(word));
        @(negedge clk_i);
        inst_i     = word;
        inst_req_i = 1'b1;
        do @(negedge clk_i); while (!inst_ack_o);
        inst_req_i = 1'b0;
        do @(negedge clk_i); while (inst_ack_o);
        accepted++;
    endtask

    task automatic check_record();
        wb_rec_t exp;
        checks++;
        assert (exp_q.size() != 0) else begin
            $display("Fail at %0t: writeback record arrived with no instruction issued", $time);
            errors++;
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            compare_value("wb_we_o", exp.we, wb_we_o);
            compare_value("wb_illegal_o", exp.illegal, wb_illegal_o);
            compare_value("wb_data_o", exp.data, wb_data_o);
            if (exp.we) compare_value("wb_addr_o", exp.addr, wb_addr_o);
        end
    endtask

    task automatic read_all_regs();
        for (int r = 0; r < N_READ; r++) begin
            send_inst({`OP_SPECIAL, 5'(r), 5'd0, 5'(r), 5'd0, `FN_OR});  // or rN, rN, r0
        end
    endtask

    task automatic start_test();
        err_mark = errors;
        chk_mark = checks;
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0 || wb_req_o || wb_ack_i) @(negedge clk_i);
        tests++;
        $display("test %s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
    endtask

    task automatic test_reset();
        start_test();
        compare_value("inst_ack_o", 1'b0, inst_ack_o);
        compare_value("wb_req_o", 1'b0, wb_req_o);
        read_all_regs();
        finish_test("reset");
    endtask

    task automatic test_immediates();
        start_test();
        for (int i = 0; i < N_IMM; i++) send_inst(gen_imm_word());
        finish_test("immediates");
    endtask

    task automatic test_rtype();
        logic [31:0] w;
        start_test();
        for (int i = 0; i < N_RTYPE; i++) send_inst(gen_rtype_word());
        for (int i = 0; i < N_R0; i++) begin
            w        = gen_rtype_word();
            w[15:11] = 5'd0;  // aim at r0
            send_inst(w);
            send_inst({`OP_SPECIAL, 5'd0, 5'd0, 5'd1, 5'd0, `FN_OR});
        end
        finish_test("rtype");
    endtask

    task automatic test_nops();
        start_test();
        for (int i = 0; i < N_NOP; i++) send_inst(gen_nop_word());
        read_all_regs();
        finish_test("nops_illegal");
    endtask

    task automatic test_backpressure();
        start_test();
        stall_mode = 1'b1;
        hold_ack   = 1'b1;
        accepted   = 0;
        fork
            begin
                for (int i = 0; i < N_BURST; i++) begin
                    if (rand_below(2) == 0) send_inst(gen_imm_word());
                    else send_inst(gen_rtype_word());
                end
            end
            begin
                repeat (STALL_WAIT) @(negedge clk_i);
                // one in execute, fifo full, one held in the decoder
                compare_value("accepted count", `FIFO_DEPTH_DEF + 2, accepted);
                compare_value("inst_ack_o", 1'b0, inst_ack_o);
                compare_value("wb_req_o", 1'b1, wb_req_o);
                hold_ack = 1'b0;
            end
        join
        finish_test("backpressure");
        stall_mode = 1'b0;
    endtask

    initial begin : wb_responder
        int unsigned delay;
        @(posedge arst_n_i);
        forever begin
            @(negedge clk_i);
            if (wb_req_o && !wb_ack_i) begin
                check_record();
                delay = stall_mode ? 20 : ($unsigned($random(ack_seed)) % 7);
                repeat (delay) @(negedge clk_i);
                while (hold_ack) @(negedge clk_i);
                wb_ack_i = 1'b1;
                while (wb_req_o) @(negedge clk_i);
                wb_ack_i = 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(TOTAL_INSTS * 40 * CLK_PERIOD);
        $display("watchdog expired, the DUT stopped completing handshakes");
        $display("Regression failed");
        $finish;
    end

    initial begin : main
        clk_i      = 1'b0;
        arst_n_i   = 1'b0;
        inst_req_i = 1'b0;
        inst_i     = '0;
        wb_ack_i   = 1'b0;
        seed       = 32'h0860_8603;
        ack_seed   = seed;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        accepted   = 0;
        stall_mode = 1'b0;
        hold_ack   = 1'b0;
        for (int r = 0; r < `NUM_REGS; r++) model_rf[r] = '0;
        repeat (2) @(negedge clk_i);
        arst_n_i = 1'b1;
        test_reset();
        test_immediates();
        test_rtype();
        test_nops();
        test_backpressure();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+hw
hw/mips_decode_pkg.sv
hw/dec_op_if.sv
hw/inst_decoder.sv
hw/op_fifo.sv
hw/alu_exec.sv
hw/mips_decode_core.sv
testbench/tb_mips_decode_core.sv

// ==== Bender.yml ====
package:
  name: mips_decode_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/mips_decode_pkg.sv
      - hw/dec_op_if.sv
      - hw/inst_decoder.sv
      - hw/op_fifo.sv
      - hw/alu_exec.sv
      - hw/mips_decode_core.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - testbench/tb_mips_decode_core.sv
